/* common/riscv_pkg.sv */
package riscv_pkg;

  // datapath geometry
  localparam int XLEN       = 64;
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = $clog2(NUM_REGS);  // 5
  localparam int SHAMT_W    = $clog2(XLEN);      // shift amount bits on rv64
  localparam int INST_W     = 32;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;
  typedef logic [3:0]            alu_op_t;

  // major opcodes still decoded
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;  // srl or sra as funct7[5] picks
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_AND   = 4'd2;
  localparam alu_op_t ALU_OR    = 4'd3;
  localparam alu_op_t ALU_XOR   = 4'd4;
  localparam alu_op_t ALU_SLL   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_SLT   = 4'd8;
  localparam alu_op_t ALU_SLTU  = 4'd9;
  localparam alu_op_t ALU_PASSB = 4'd10;  // lui passes operand b through

  // decoded control for one instruction
  typedef struct packed {
    logic      regw;     // writes rd
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      use_imm;  // operand b from imm
    xlen_t     imm;
  } dec_ctrl_t;

  // decode/execute register
  typedef struct packed {
    logic      valid;
    dec_ctrl_t ctrl;
    reg_addr_t rs1_addr;
    xlen_t     rs1_data;
    reg_addr_t rs2_addr;
    xlen_t     rs2_data;
  } de_bus_t;

  // execute/writeback register that doubles as the retire port
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } wb_bus_t;

endpackage

/* design/decode/riscv_decoder.sv */
`timescale 1ns/1ns

module riscv_decoder (
  input  riscv_pkg::inst_t     i_inst,
  output logic                 o_valid,
  output riscv_pkg::dec_ctrl_t o_ctrl,
  output riscv_pkg::reg_addr_t o_rs1_addr,
  output riscv_pkg::reg_addr_t o_rs2_addr
);
  import riscv_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  logic      f7_b5;
  reg_addr_t rd;
  xlen_t     imm_i;
  xlen_t     imm_u;
  alu_op_t   f3_op;  // alu op as funct3 alone gives it

  assign opcode = i_inst[6:0];
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign f7_b5  = i_inst[30];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};  // sign extended on rv64

  always_comb begin
    case (funct3)
      F3_ADD_SUB: f3_op = ALU_ADD;
      F3_SLL:     f3_op = ALU_SLL;
      F3_SLT:     f3_op = ALU_SLT;
      F3_SLTU:    f3_op = ALU_SLTU;
      F3_XOR:     f3_op = ALU_XOR;
      F3_SR:      f3_op = f7_b5 ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 too
      F3_OR:      f3_op = ALU_OR;
      F3_AND:     f3_op = ALU_AND;
      default:    f3_op = ALU_ADD;
    endcase
  end

  always_comb begin
    o_valid    = 1'b0;
    o_ctrl     = '0;
    o_rs1_addr = i_inst[19:15];
    o_rs2_addr = i_inst[24:20];
    case (opcode)
      OPC_OP: begin
        o_valid       = 1'b1;
        o_ctrl.alu_op = (funct3 == F3_ADD_SUB && f7_b5) ? ALU_SUB : f3_op;
      end
      OPC_OP_IMM: begin
        o_valid        = 1'b1;
        o_ctrl.alu_op  = f3_op;  // there is no subi
        o_ctrl.use_imm = 1'b1;
        o_ctrl.imm     = imm_i;
      end
      OPC_LUI: begin
        o_valid        = 1'b1;
        o_ctrl.alu_op  = ALU_PASSB;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.imm     = imm_u;
        o_rs1_addr     = '0;  // no source register for lui
      end
      default: begin
        o_valid = 1'b0;  // anything else becomes a bubble
      end
    endcase
    o_ctrl.rd   = rd;
    o_ctrl.regw = o_valid && (rd != '0);
  end

endmodule

/* design/decode/riscv_dstage.sv */
`timescale 1ns/1ns

module riscv_dstage (
  input  logic                 i_riscv_datapath_clk,
  input  logic                 i_rst_n,
  input  riscv_pkg::inst_t     i_inst,
  input  logic                 i_inst_valid,
  input  logic                 i_stall,
  // register file read port
  output riscv_pkg::reg_addr_t o_rs1_addr,
  output riscv_pkg::reg_addr_t o_rs2_addr,
  input  riscv_pkg::xlen_t     i_rs1_data,
  input  riscv_pkg::xlen_t     i_rs2_data,
  output riscv_pkg::de_bus_t   o_de
);
  import riscv_pkg::*;

  logic      dec_valid;
  dec_ctrl_t dec_ctrl;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  de_bus_t   de_d;

  riscv_decoder u_riscv_decoder (
    .i_inst     (i_inst),
    .o_valid    (dec_valid),
    .o_ctrl     (dec_ctrl),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr)
  );

  assign o_rs1_addr = rs1_addr;
  assign o_rs2_addr = rs2_addr;

  // next content of the d/e register
  always_comb begin
    de_d          = '0;
    de_d.valid    = dec_valid & i_inst_valid;
    de_d.ctrl     = dec_ctrl;
    de_d.rs1_addr = rs1_addr;
    de_d.rs1_data = i_rs1_data;  // already bypassed by the regfile
    de_d.rs2_addr = rs2_addr;
    de_d.rs2_data = i_rs2_data;
  end

  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_de <= '0;
    end else if (!i_stall) begin  // hold the whole register on stall
      o_de <= de_d;
    end
  end

endmodule

/* design/riscv_regfile.sv */
`timescale 1ns/1ns

module riscv_regfile (
  input  logic                 i_riscv_datapath_clk,
  input  logic                 i_rst_n,
  input  riscv_pkg::wb_bus_t   i_wr,
  input  logic                 i_wr_en,
  input  riscv_pkg::reg_addr_t i_rs1_addr,
  input  riscv_pkg::reg_addr_t i_rs2_addr,
  output riscv_pkg::xlen_t     o_rs1_data,
  output riscv_pkg::xlen_t     o_rs2_data
);
  import riscv_pkg::*;

  xlen_t regs [1:NUM_REGS-1];  // x0 has no storage
  logic  wr_hit1;
  logic  wr_hit2;

  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && (i_wr.rd != '0)) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

  // same cycle write goes straight to the read port
  assign wr_hit1 = i_wr_en && (i_wr.rd == i_rs1_addr);
  assign wr_hit2 = i_wr_en && (i_wr.rd == i_rs2_addr);

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      wr_hit1            ? i_wr.data : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      wr_hit2            ? i_wr.data : regs[i_rs2_addr];

endmodule

/* design/execute/riscv_alu.sv */
`timescale 1ns/1ns

module riscv_alu (
  input  riscv_pkg::alu_op_t i_alu_op,
  input  riscv_pkg::xlen_t   i_a,
  input  riscv_pkg::xlen_t   i_b,
  output riscv_pkg::xlen_t   o_result
);
  import riscv_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  assign shamt = i_b[SHAMT_W-1:0];  // low 6 bits only
  assign lt_s  = $signed(i_a) < $signed(i_b);
  assign lt_u  = i_a < i_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD: begin
        o_result = i_a + i_b;
      end
      ALU_SUB: begin
        o_result = i_a - i_b;
      end
      ALU_AND:   o_result = i_a & i_b;
      ALU_OR:    o_result = i_a | i_b;
      ALU_XOR:   o_result = i_a ^ i_b;
      ALU_SLL:   o_result = i_a << shamt;
      ALU_SRL:   o_result = i_a >> shamt;
      ALU_SRA: begin
        o_result = xlen_t'($signed(i_a) >>> shamt);  // keeps the sign
      end
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_PASSB: o_result = i_b;
      default:   o_result = '0;
    endcase
  end

endmodule

/* design/execute/riscv_estage.sv */
`timescale 1ns/1ns

module riscv_estage (
  input  logic               i_riscv_datapath_clk,
  input  logic               i_rst_n,
  input  logic               i_stall,
  input  riscv_pkg::de_bus_t i_de,
  output riscv_pkg::wb_bus_t o_wb
);
  import riscv_pkg::*;

  logic    fwd_valid;
  logic    fwd_a;
  logic    fwd_b;
  xlen_t   opnd_a;
  xlen_t   rs2_val;
  xlen_t   opnd_b;
  xlen_t   alu_result;
  wb_bus_t wb_d;

  // result one ahead sits in our own e/w register
  assign fwd_valid = o_wb.valid && (o_wb.rd != '0);
  assign fwd_a     = fwd_valid && (o_wb.rd == i_de.rs1_addr);
  assign fwd_b     = fwd_valid && (o_wb.rd == i_de.rs2_addr);

  assign opnd_a  = fwd_a ? o_wb.data : i_de.rs1_data;
  assign rs2_val = fwd_b ? o_wb.data : i_de.rs2_data;
  assign opnd_b  = i_de.ctrl.use_imm ? i_de.ctrl.imm : rs2_val;

  riscv_alu u_riscv_alu (
    .i_alu_op (i_de.ctrl.alu_op),
    .i_a      (opnd_a),
    .i_b      (opnd_b),
    .o_result (alu_result)
  );

  always_comb begin
    wb_d       = '0;
    wb_d.valid = i_de.valid & i_de.ctrl.regw;  // bubbles and x0 never retire
    wb_d.rd    = i_de.ctrl.rd;
    wb_d.data  = alu_result;
  end

  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb <= '0;
    end else if (!i_stall) begin
      o_wb <= wb_d;
    end
  end

endmodule

/* design/riscv_datapath.sv */
`timescale 1ns/1ns

module riscv_datapath (
  input  logic               i_riscv_datapath_clk,
  input  logic               i_rst_n,
  input  riscv_pkg::inst_t   i_inst,
  input  logic               i_inst_valid,
  input  logic               i_stall,
  output riscv_pkg::wb_bus_t o_wb
);
  import riscv_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  de_bus_t   de_bus;
  logic      rf_wr_en;

  // write only on a retire edge and never while stalled
  assign rf_wr_en = o_wb.valid & ~i_stall;

  riscv_dstage u_riscv_dstage (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_inst               (i_inst),
    .i_inst_valid         (i_inst_valid),
    .i_stall              (i_stall),
    .o_rs1_addr           (rs1_addr),
    .o_rs2_addr           (rs2_addr),
    .i_rs1_data           (rs1_data),
    .i_rs2_data           (rs2_data),
    .o_de                 (de_bus)
  );

  riscv_regfile u_riscv_regfile (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_wr                 (o_wb),
    .i_wr_en              (rf_wr_en),
    .i_rs1_addr           (rs1_addr),
    .i_rs2_addr           (rs2_addr),
    .o_rs1_data           (rs1_data),
    .o_rs2_data           (rs2_data)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_stall              (i_stall),
    .i_de                 (de_bus),
    .o_wb                 (o_wb)  // also feeds regfile write and forwarding
  );

endmodule

/* sim/riscv_model.svh */
`ifndef RISCV_MODEL_SVH
`define RISCV_MODEL_SVH

// uniform draw in 0..n-1 from the seeded stream
function automatic int unsigned rand_below(input int unsigned n);
  int unsigned r;
  r = $random(seed);
  return r % n;
endfunction

// opcodes the datapath does not keep
function automatic opcode_t pick_unkept_opcode();
  case (rand_below(6))
    0:       return 7'b0000011;  // load
    1:       return 7'b0100011;  // store
    2:       return 7'b1100011;  // branch
    3:       return 7'b1101111;  // jal
    4:       return 7'b0010111;  // auipc
    default: return 7'b0111011;  // op-32
  endcase
endfunction

// weighted instruction mix over x0..x5 for dense dependencies
function automatic inst_t gen_inst();
  int unsigned pick;
  funct3_t     f3;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic        alt;
  logic [11:0] imm;
  logic [31:0] rbits;
  inst_t       w;
  pick  = rand_below(100);
  f3    = funct3_t'(rand_below(8));
  rd    = reg_addr_t'(1 + rand_below(5));
  rs1   = reg_addr_t'(rand_below(6));
  rs2   = reg_addr_t'(rand_below(6));
  alt   = rand_below(2) != 0;
  imm   = 12'(rand_below(4096));
  rbits = $random(seed);
  if (pick >= 94) begin
    rd   = '0;  // kept op aimed at x0
    pick = (pick < 97) ? 0 : 50;
  end
  if (pick < 45) begin
    w = {1'b0, alt && (f3 == F3_ADD_SUB || f3 == F3_SR), 5'b0, rs2, rs1, f3, rd, OPC_OP};
  end else if (pick < 80) begin
    if (f3 == F3_SLL || f3 == F3_SR) begin
      imm = {1'b0, alt && (f3 == F3_SR), 4'b0, imm[5:0]};  // shamt form
    end
    w = {imm, rs1, f3, rd, OPC_OP_IMM};
  end else if (pick < 88) begin
    w = {rbits[31:12], rd, OPC_LUI};
  end else begin
    w = {rbits[31:7], pick_unkept_opcode()};
  end
  return w;
endfunction

// program-order result of one accepted instruction
task automatic predict(input inst_t w);
  opcode_t    opc;
  funct3_t    f3;
  reg_addr_t  rd;
  xlen_t      a;
  xlen_t      b;
  xlen_t      res;
  logic [5:0] sh;
  logic       kept;
  wb_bus_t    e;
  opc  = w[6:0];
  f3   = w[14:12];
  rd   = w[11:7];
  a    = model_regs[w[19:15]];
  b    = (opc == OPC_OP) ? model_regs[w[24:20]] : {{(XLEN-12){w[31]}}, w[31:20]};
  sh   = b[5:0];
  kept = 1'b1;
  res  = '0;
  if (opc == OPC_LUI) begin
    res = {{(XLEN-32){w[31]}}, w[31:12], 12'h000};
  end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
    case (f3)
      F3_ADD_SUB: res = (opc == OPC_OP && w[30]) ? a - b : a + b;
      F3_SLL:     res = a << sh;
      F3_SLT:     res = ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
      F3_SLTU:    res = (a < b) ? xlen_t'(1) : xlen_t'(0);
      F3_XOR:     res = a ^ b;
      F3_SR: begin
        res = a >> sh;
        if (w[30] && a[XLEN-1]) begin
          res = res | ~({XLEN{1'b1}} >> sh);  // fill in the sign
        end
      end
      F3_OR:      res = a | b;
      default:    res = a & b;
    endcase
  end else begin
    kept = 1'b0;  // bubble
  end
  if (kept && rd != '0) begin
    e.valid = 1'b1;
    e.rd    = rd;
    e.data  = res;
    exp_q.push_back(e);
    model_regs[rd] = res;
  end
endtask

task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
  if (got !== exp) begin
    report_failure($sformatf("** Error at %0t ns: o_wb.rd is x%0d, expected x%0d",
                             $time, got, exp));
  end
endtask

task automatic check_data(input xlen_t got, input xlen_t exp);
  if (got !== exp) begin
    report_failure($sformatf("** Error at %0t ns: o_wb.data is %h, expected %h",
                             $time, got, exp));
  end
endtask

task automatic check_hold(input wb_bus_t got, input wb_bus_t exp);
  if (got !== exp) begin
    report_failure($sformatf("** Error at %0t ns: o_wb moved under stall, %h, expected %h",
                             $time, got, exp));
  end
endtask

`endif

/* sim/tb_riscv_datapath.sv */
`timescale 1ns/1ns

module tb_riscv_datapath;
  import riscv_pkg::*;

  localparam int N_INST    = 3000;
  localparam int CLK_HALF  = 4;
  localparam int RST_CYC   = 3;
  localparam int DRAIN_CYC = 4;  // two unstalled edges retire the last one

  logic    clk;
  logic    rst_n;
  inst_t   inst;
  logic    inst_valid;
  logic    stall;
  wb_bus_t wb;

  integer  seed;
  xlen_t   model_regs [0:NUM_REGS-1];
  wb_bus_t exp_q [$];  // results in acceptance order
  int      accepted;
  wb_bus_t prev_wb;
  logic    prev_stall;  // stall that applied at the last rising edge

  riscv_datapath riscv_datapath_inst (
    .i_riscv_datapath_clk (clk),
    .i_rst_n              (rst_n),
    .i_inst               (inst),
    .i_inst_valid         (inst_valid),
    .i_stall              (stall),
    .o_wb                 (wb)
  );

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "riscv_model.svh"

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // bound on the whole run
  initial begin
    repeat (N_INST * 4 + 100) @(posedge clk);
    report_failure($sformatf("watchdog expired at %0t ns before all instructions were sent",
                             $time));
  end

  // o_wb is stable here and stall is still the one the last edge saw
  task automatic monitor_cycle();
    wb_bus_t exp;
    if (prev_stall) begin
      check_hold(wb, prev_wb);
    end
    if (wb.valid && !stall) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("x%0d retired at %0t ns with no instruction outstanding",
                                 wb.rd, $time));
      end else begin
        exp = exp_q.pop_front();
        check_rd(wb.rd, exp.rd);
        check_data(wb.data, exp.data);
      end
    end
  endtask

  task automatic drive_cycle();
    stall      = rand_below(100) < 25;
    inst_valid = rand_below(100) < 80;
    inst       = gen_inst();
    if (inst_valid && !stall) begin
      predict(inst);  // accepted at the coming edge
      accepted++;
    end
  endtask

  initial begin
    seed       = 89;
    rst_n      = 1'b0;
    inst       = '0;
    inst_valid = 1'b0;
    stall      = 1'b0;
    accepted   = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst_n      = 1'b1;
    prev_wb    = wb;
    prev_stall = 1'b0;

    while (accepted < N_INST) begin
      @(negedge clk);
      monitor_cycle();
      drive_cycle();
      prev_wb    = wb;
      prev_stall = stall;
    end

    // idle tail so the last two in flight retire
    repeat (DRAIN_CYC) begin
      @(negedge clk);
      monitor_cycle();
      stall      = 1'b0;
      inst_valid = 1'b0;
      prev_wb    = wb;
      prev_stall = stall;
    end

    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected results never retired", exp_q.size()));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+sim
common/riscv_pkg.sv
design/decode/riscv_decoder.sv
design/decode/riscv_dstage.sv
design/riscv_regfile.sv
design/execute/riscv_alu.sv
design/execute/riscv_estage.sv
design/riscv_datapath.sv
sim/tb_riscv_datapath.sv
